// ==== common/commit_pkg.sv ====
// commit stage shared definitions
package commit_pkg;

  // --------------------------------------------------------------------------
  // widths and sizes
  // --------------------------------------------------------------------------
  // integer register width
  localparam int unsigned XLEN            = 64;
  // program counter width
  localparam int unsigned VLEN            = 64;
  // scoreboard transaction id width
  localparam int unsigned TRANS_ID_BITS   = 3;
  // the follow-port rules assume exactly two ports
  localparam int unsigned NR_COMMIT_PORTS = 2;
  // accrued fp exception flags (NV DZ OF UF NX)
  localparam int unsigned FFLAGS_BITS     = 5;

  // --------------------------------------------------------------------------
  // unit and operation codes
  // --------------------------------------------------------------------------
  // functional unit that executed the entry
  typedef enum logic [2:0] {
    NONE, ALU, LOAD, STORE, CTRL_FLOW, MULT, CSR, FPU
  } fu_e;

  // only the operations retirement has to tell apart
  typedef enum logic [3:0] {
    OP_OTHER, OP_FENCE, OP_FENCE_I, OP_AMO,
    CSR_NOP, CSR_WRITE, CSR_SET, CSR_CLEAR
  } op_e;

  // --------------------------------------------------------------------------
  // packed payloads
  // --------------------------------------------------------------------------
  // synchronous trap raised somewhere in the pipeline
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // one scoreboard entry offered for retirement
  typedef struct packed {
    logic                     valid;
    logic [VLEN-1:0]          pc;
    logic [TRANS_ID_BITS-1:0] trans_id;
    fu_e                      fu;
    op_e                      op;
    logic [4:0]               rd;
    logic                     rd_is_fpr;
    logic [XLEN-1:0]          result;
    exception_t               ex;
  } sb_entry_t;

  // one register file write port
  typedef struct packed {
    logic            we_gpr;
    logic            we_fpr;
    logic [4:0]      waddr;
    logic [XLEN-1:0] wdata;
  } rf_write_t;

  // request towards the csr file
  typedef struct packed {
    op_e             op;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  // atomic memory operation response from the data cache
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] result;
  } amo_resp_t;

endpackage

// ==== commit/commit_lead.sv ====
// commit port 0 retirement
`timescale 1ns/1ps

module commit_lead #(
  parameter bit FP_PRESENT  = 1'b1,
  parameter bit AMO_PRESENT = 1'b1
) (
  input  commit_pkg::sb_entry_t       instr_i,
  input  logic                        drop_i,
  input  logic                        halt_i,
  input  logic                        lsu_ready_i,
  input  logic                        no_st_pending_i,
  input  commit_pkg::amo_resp_t       amo_resp_i,
  input  logic [commit_pkg::XLEN-1:0] csr_rdata_i,
  input  logic                        csr_exception_valid_i,
  output logic                        ack_o,
  output commit_pkg::rf_write_t       wr_o,
  output logic                        pair_ok_o,
  output commit_pkg::csr_req_t        csr_req_o,
  output logic                        commit_csr_o,
  output logic                        commit_lsu_o,
  output logic                        amo_valid_o,
  output logic                        fence_o,
  output logic                        fence_i_o,
  output logic                        flush_o
);

  logic is_amo;
  logic amo_done;

  // atomics only exist when the A extension is built in
  assign is_amo   = AMO_PRESENT && (instr_i.op == commit_pkg::OP_AMO);
  assign amo_done = AMO_PRESENT && amo_resp_i.ack;

  // --------------------------------------------------------------------------
  // retirement decision
  // --------------------------------------------------------------------------
  always_comb begin
    ack_o           = 1'b0;
    wr_o.we_gpr     = 1'b0;
    wr_o.we_fpr     = 1'b0;
    wr_o.waddr      = instr_i.rd;
    wr_o.wdata      = instr_i.result;
    // csr nop unless a csr instruction retires
    csr_req_o.op    = commit_pkg::CSR_NOP;
    csr_req_o.wdata = '0;
    commit_csr_o    = 1'b0;
    commit_lsu_o    = 1'b0;
    amo_valid_o     = 1'b0;
    fence_o         = 1'b0;
    fence_i_o       = 1'b0;
    flush_o         = 1'b0;

    // a halt request freezes retirement
    if (instr_i.valid && !halt_i) begin
      if (instr_i.ex.valid) begin
        // faulting entry only leaves when squashed
        ack_o = drop_i;
      end else begin
        ack_o = 1'b1;
        if (!drop_i) begin
          if (FP_PRESENT && instr_i.rd_is_fpr) begin
            wr_o.we_fpr = 1'b1;
          end else begin
            wr_o.we_gpr = 1'b1;
          end
        end

        // store buffer full, entry stays offered
        if (instr_i.fu == commit_pkg::STORE && !is_amo) begin
          if (lsu_ready_i) begin
            commit_lsu_o = 1'b1;
          end else begin
            ack_o = 1'b0;
          end
        end

        // csr access, the csr file may still refuse it
        if (instr_i.fu == commit_pkg::CSR) begin
          csr_req_o.op    = instr_i.op;
          csr_req_o.wdata = instr_i.result;
          if (!drop_i) begin
            if (!csr_exception_valid_i) begin
              commit_csr_o = 1'b1;
              wr_o.wdata   = csr_rdata_i;
            end else begin
              ack_o       = 1'b0;
              wr_o.we_gpr = 1'b0;
            end
          end
        end

        // fence.i waits for the store buffer to drain
        if (instr_i.op == commit_pkg::OP_FENCE_I && !drop_i) begin
          ack_o     = no_st_pending_i;
          fence_i_o = no_st_pending_i;
        end

        // same for a plain fence
        if (instr_i.op == commit_pkg::OP_FENCE && !drop_i) begin
          ack_o   = no_st_pending_i;
          fence_o = no_st_pending_i;
        end

        // amo retires with the cache response and flushes the pipe
        if (is_amo) begin
          amo_valid_o = 1'b1;
          ack_o       = amo_resp_i.ack;
          flush_o     = amo_resp_i.ack;
          wr_o.we_gpr = amo_resp_i.ack;
        end
      end
    end

    // amo result has the highest write data priority
    if (amo_done) begin
      wr_o.wdata = amo_resp_i.result;
    end
  end

  // port 1 may only follow plain instructions
  assign pair_ok_o = ack_o && (instr_i.fu != commit_pkg::CSR) && !is_amo;

endmodule

// ==== commit/commit_follow.sv ====
// commit port 1 dual retirement
`timescale 1ns/1ps

module commit_follow #(
  parameter bit FP_PRESENT = 1'b1
) (
  input  commit_pkg::sb_entry_t instr_i,
  input  logic                  drop_i,
  input  logic                  pair_ok_i,
  input  logic                  single_step_i,
  output logic                  ack_o,
  output commit_pkg::rf_write_t wr_o
);

  logic unit_ok;
  logic writes;

  // --------------------------------------------------------------------------
  // pairing rules
  // --------------------------------------------------------------------------
  // units whose results need no side effect beyond the register file
  assign unit_ok = instr_i.fu inside {commit_pkg::ALU, commit_pkg::LOAD,
                                      commit_pkg::CTRL_FLOW, commit_pkg::MULT,
                                      commit_pkg::FPU};

  // pair_ok_i already covers halt and a retiring port 0
  // single step keeps retirement to one entry per cycle
  assign ack_o = pair_ok_i && !single_step_i && instr_i.valid
                 && !instr_i.ex.valid && unit_ok;

  // a squashed entry retires without touching the register file
  assign writes = ack_o && !drop_i;

  // --------------------------------------------------------------------------
  // register file write
  // --------------------------------------------------------------------------
  always_comb begin
    wr_o.waddr  = instr_i.rd;
    wr_o.wdata  = instr_i.result;
    wr_o.we_gpr = 1'b0;
    wr_o.we_fpr = 1'b0;
    if (writes) begin
      // fp destination only when the fp register file exists
      if (FP_PRESENT && instr_i.rd_is_fpr) begin
        wr_o.we_fpr = 1'b1;
      end else begin
        wr_o.we_gpr = 1'b1;
      end
    end
  end

endmodule

// ==== src/commit_exception.sv ====
// commit exception select
`timescale 1ns/1ps

module commit_exception (
  input  commit_pkg::sb_entry_t  instr_i,
  input  logic                   drop_i,
  input  logic                   halt_i,
  input  commit_pkg::exception_t csr_exception_i,
  output commit_pkg::exception_t exception_o
);

  // interrupts are ranked inside the csr file
  // only synchronous traps are ordered here
  always_comb begin
    exception_o = '0;

    // needs a live entry at the head of the scoreboard
    if (instr_i.valid && !drop_i) begin
      // csr access fault, tval comes from the entry itself
      if (csr_exception_i.valid) begin
        exception_o      = csr_exception_i;
        exception_o.tval = instr_i.ex.tval;
      end

      // earlier pipeline exception wins
      if (instr_i.ex.valid) begin
        exception_o = instr_i.ex;
      end
    end

    // no trap is taken while halted
    if (halt_i) begin
      exception_o.valid = 1'b0;
    end
  end

endmodule

// ==== src/fp_status.sv ====
// floating point status
`timescale 1ns/1ps

module fp_status #(
  parameter bit FP_PRESENT = 1'b1
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic                                                clr_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]              ack_i,
  input  commit_pkg::sb_entry_t [commit_pkg::NR_COMMIT_PORTS-1:0] instr_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]              drop_i,
  output logic [commit_pkg::FFLAGS_BITS-1:0]                  fflags_o,
  output logic                                                fs_dirty_o
);

  logic [commit_pkg::FFLAGS_BITS-1:0] flags_set;
  logic                               dirty_set;
  logic [commit_pkg::FFLAGS_BITS-1:0] fflags_q;
  logic                               dirty_q;

  // --------------------------------------------------------------------------
  // retired fp work this cycle
  // --------------------------------------------------------------------------
  always_comb begin
    flags_set = '0;
    dirty_set = 1'b0;
    for (int i = 0; i < commit_pkg::NR_COMMIT_PORTS; i++) begin
      // fpu carries its flags in the low cause bits
      if (ack_i[i] && instr_i[i].fu == commit_pkg::FPU) begin
        dirty_set = 1'b1;
        if (!drop_i[i]) begin
          flags_set |= instr_i[i].ex.cause[commit_pkg::FFLAGS_BITS-1:0];
        end
      end
      // any fpr write dirties the fp state too
      if (ack_i[i] && !drop_i[i] && instr_i[i].rd_is_fpr) begin
        dirty_set = 1'b1;
      end
    end
    // without an fpu nothing ever sets
    if (!FP_PRESENT) begin
      flags_set = '0;
      dirty_set = 1'b0;
    end
  end

  // sticky state, clear beats a same-cycle update
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fflags_q <= '0;
      dirty_q  <= 1'b0;
    end else if (clr_i) begin
      fflags_q <= '0;
      dirty_q  <= 1'b0;
    end else begin
      fflags_q <= fflags_q | flags_set;
      dirty_q  <= dirty_q | dirty_set;
    end
  end

  assign fflags_o   = fflags_q;
  assign fs_dirty_o = dirty_q;

endmodule

// ==== src/commit_stage.sv ====
// commit stage top
`timescale 1ns/1ps

module commit_stage #(
  parameter bit FP_PRESENT  = 1'b1,
  parameter bit AMO_PRESENT = 1'b1
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  // issue side
  input  commit_pkg::sb_entry_t [commit_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [commit_pkg::NR_COMMIT_PORTS-1:0]              commit_drop_i,
  // controller
  input  logic                                                halt_i,
  input  logic                                                single_step_i,
  // load/store unit and cache
  input  logic                                                commit_lsu_ready_i,
  input  logic                                                no_st_pending_i,
  input  commit_pkg::amo_resp_t                               amo_resp_i,
  // csr file
  input  logic [commit_pkg::XLEN-1:0]                         csr_rdata_i,
  input  commit_pkg::exception_t                              csr_exception_i,
  input  logic                                                fp_status_clr_i,
  output logic [commit_pkg::NR_COMMIT_PORTS-1:0]              commit_ack_o,
  output commit_pkg::rf_write_t [commit_pkg::NR_COMMIT_PORTS-1:0] wb_o,
  output commit_pkg::csr_req_t                                csr_req_o,
  output logic                                                commit_csr_o,
  output logic                                                commit_lsu_o,
  output logic                                                amo_valid_commit_o,
  output logic                                                fence_o,
  output logic                                                fence_i_o,
  output logic                                                flush_commit_o,
  output commit_pkg::exception_t                              exception_o,
  output logic [commit_pkg::VLEN-1:0]                         pc_o,
  output logic [commit_pkg::TRANS_ID_BITS-1:0]                commit_tran_id_o,
  output logic [commit_pkg::FFLAGS_BITS-1:0]                  fflags_o,
  output logic                                                fs_dirty_o
);

  // port 0 retires a plain instruction, port 1 may join
  logic pair_ok;

  // --------------------------------------------------------------------------
  // decision chain, lead then follow
  // --------------------------------------------------------------------------
  commit_lead #(
    .FP_PRESENT (FP_PRESENT),
    .AMO_PRESENT(AMO_PRESENT)
  ) i_commit_lead (
    .instr_i              (commit_instr_i[0]),
    .drop_i               (commit_drop_i[0]),
    .halt_i               (halt_i),
    .lsu_ready_i          (commit_lsu_ready_i),
    .no_st_pending_i      (no_st_pending_i),
    .amo_resp_i           (amo_resp_i),
    .csr_rdata_i          (csr_rdata_i),
    .csr_exception_valid_i(csr_exception_i.valid),
    .ack_o                (commit_ack_o[0]),
    .wr_o                 (wb_o[0]),
    .pair_ok_o            (pair_ok),
    .csr_req_o            (csr_req_o),
    .commit_csr_o         (commit_csr_o),
    .commit_lsu_o         (commit_lsu_o),
    .amo_valid_o          (amo_valid_commit_o),
    .fence_o              (fence_o),
    .fence_i_o            (fence_i_o),
    .flush_o              (flush_commit_o)
  );

  commit_follow #(
    .FP_PRESENT(FP_PRESENT)
  ) i_commit_follow (
    .instr_i      (commit_instr_i[1]),
    .drop_i       (commit_drop_i[1]),
    .pair_ok_i    (pair_ok),
    .single_step_i(single_step_i),
    .ack_o        (commit_ack_o[1]),
    .wr_o         (wb_o[1])
  );

  // --------------------------------------------------------------------------
  // trap select and fp status
  // --------------------------------------------------------------------------
  commit_exception i_commit_exception (
    .instr_i        (commit_instr_i[0]),
    .drop_i         (commit_drop_i[0]),
    .halt_i         (halt_i),
    .csr_exception_i(csr_exception_i),
    .exception_o    (exception_o)
  );

  fp_status #(
    .FP_PRESENT(FP_PRESENT)
  ) i_fp_status (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .clr_i     (fp_status_clr_i),
    .ack_i     (commit_ack_o),
    .instr_i   (commit_instr_i),
    .drop_i    (commit_drop_i),
    .fflags_o  (fflags_o),
    .fs_dirty_o(fs_dirty_o)
  );

  // head of the scoreboard identifies the retiring instruction
  assign pc_o             = commit_instr_i[0].pc;
  assign commit_tran_id_o = commit_instr_i[0].trans_id;

endmodule

// ==== dv/commit_stage_assert.sv ====
// commit port 0 invariants
`timescale 1ns/1ps

module commit_stage_assert (
  input logic clk_i,
  input logic arst_n_i,
  input logic ack0_i,
  input logic drop0_i,
  input logic ex_valid0_i,
  input logic lsu_commit_i,
  input logic lsu_ready_i,
  input logic fence_seen_i,
  input logic fence_i_seen_i,
  input logic no_st_pending_i
);

  // a faulting entry leaves only when squashed
  ack_no_live_fault: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(ack0_i && ex_valid0_i && !drop0_i))
    else $error("port 0 retired an entry with a live exception");

  // store commit needs room in the store buffer
  lsu_needs_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    lsu_commit_i |-> lsu_ready_i)
    else $error("store committed while the store buffer was full");

  // fences only with a drained store buffer
  fence_needs_drain: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (fence_seen_i || fence_i_seen_i) |-> no_st_pending_i)
    else $error("fence committed with stores pending");

endmodule

// port 0 decision signals as seen at the top level
bind commit_stage commit_stage_assert i_commit_stage_assert (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .ack0_i         (commit_ack_o[0]),
  .drop0_i        (commit_drop_i[0]),
  .ex_valid0_i    (commit_instr_i[0].ex.valid),
  .lsu_commit_i   (commit_lsu_o),
  .lsu_ready_i    (commit_lsu_ready_i),
  .fence_seen_i   (fence_o),
  .fence_i_seen_i (fence_i_o),
  .no_st_pending_i(no_st_pending_i)
);

// ==== dv/tb_commit_stage.sv ====
// commit stage testbench
`timescale 1ns/1ps

module tb_commit_stage;

  localparam bit          FP_PRESENT   = 1'b1;
  localparam bit          AMO_PRESENT  = 1'b1;
  localparam int          CLK_PERIOD   = 20;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          SAMPLE_DELAY = 18;
  localparam int          RESET_CYCLES = 16;
  localparam int          TEST_CYCLES  = 400;
  localparam int          NUM_TESTS    = 6;
  localparam int          TIMEOUT_NS   =
    (RESET_CYCLES + NUM_TESTS * (TEST_CYCLES + 1) + 100) * CLK_PERIOD;
  localparam logic [31:0] SEED         = 32'h62f7c463;

  // everything the reference predicts for one cycle
  typedef struct packed {
    logic [1:0]             ack;
    commit_pkg::rf_write_t  w0;
    commit_pkg::rf_write_t  w1;
    commit_pkg::csr_req_t   csr;
    logic                   csr_commit;
    logic                   lsu;
    logic                   amo_valid;
    logic                   fence;
    logic                   fence_i;
    logic                   flush;
    commit_pkg::exception_t ex;
    logic [4:0]             flags_set;
    logic                   dirty_set;
  } expect_t;

  logic                                   clk_i;
  logic                                   arst_n_i;
  commit_pkg::sb_entry_t [1:0]            commit_instr_i;
  logic [1:0]                             commit_drop_i;
  logic                                   halt_i;
  logic                                   single_step_i;
  logic                                   commit_lsu_ready_i;
  logic                                   no_st_pending_i;
  commit_pkg::amo_resp_t                  amo_resp_i;
  logic [commit_pkg::XLEN-1:0]            csr_rdata_i;
  commit_pkg::exception_t                 csr_exception_i;
  logic                                   fp_status_clr_i;
  logic [1:0]                             commit_ack_o;
  commit_pkg::rf_write_t [1:0]            wb_o;
  commit_pkg::csr_req_t                   csr_req_o;
  logic                                   commit_csr_o;
  logic                                   commit_lsu_o;
  logic                                   amo_valid_commit_o;
  logic                                   fence_o;
  logic                                   fence_i_o;
  logic                                   flush_commit_o;
  commit_pkg::exception_t                 exception_o;
  logic [commit_pkg::VLEN-1:0]            pc_o;
  logic [commit_pkg::TRANS_ID_BITS-1:0]   commit_tran_id_o;
  logic [commit_pkg::FFLAGS_BITS-1:0]     fflags_o;
  logic                                   fs_dirty_o;

  logic [31:0] lfsr;
  int          mode;
  int          errors;
  int          checks;
  // fp status model advanced once per edge
  logic [4:0]  flags_q;
  logic        dirty_q;

  commit_stage #(
    .FP_PRESENT (FP_PRESENT),
    .AMO_PRESENT(AMO_PRESENT)
  ) DUT (
    .clk_i, .arst_n_i, .commit_instr_i, .commit_drop_i, .halt_i, .single_step_i,
    .commit_lsu_ready_i, .no_st_pending_i, .amo_resp_i, .csr_rdata_i, .csr_exception_i,
    .fp_status_clr_i, .commit_ack_o, .wb_o, .csr_req_o, .commit_csr_o, .commit_lsu_o,
    .amo_valid_commit_o, .fence_o, .fence_i_o, .flush_commit_o, .exception_o, .pc_o,
    .commit_tran_id_o, .fflags_o, .fs_dirty_o
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // random source
  // --------------------------------------------------------------------------
  // right shifting galois lfsr
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] take_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // true once in 2**n
  function automatic bit chance(int n);
    return take_bits(n) == 0;
  endfunction

  function automatic bit coin();
    return take_bits(1) == 1;
  endfunction

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------
  function automatic commit_pkg::sb_entry_t new_entry(int port);
    commit_pkg::sb_entry_t s;
    s.valid    = !chance(3);
    s.pc       = take_bits(64);
    s.trans_id = 3'(take_bits(3));
    s.fu       = commit_pkg::fu_e'(3'(take_bits(3)));
    // weight the unit toward what the current test exercises
    if ((port == 0 || mode == 2) && !chance(2)) begin
      case (mode)
        2: s.fu = coin() ? commit_pkg::FPU : commit_pkg::ALU;
        3: s.fu = commit_pkg::STORE;
        4: s.fu = commit_pkg::ALU;
        5: s.fu = commit_pkg::CSR;
        6: s.fu = coin() ? commit_pkg::STORE : commit_pkg::LOAD;
        default: ;
      endcase
    end
    // op kept consistent with the unit
    s.op = commit_pkg::OP_OTHER;
    if (s.fu == commit_pkg::CSR) begin
      s.op = commit_pkg::op_e'(4'd4 + 4'(take_bits(2)));
    end else if (s.fu == commit_pkg::LOAD || s.fu == commit_pkg::STORE) begin
      if (mode == 6 ? coin() : chance(3)) begin
        s.op = commit_pkg::OP_AMO;
      end
    end else if (mode == 4 ? coin() : chance(3)) begin
      s.op = coin() ? commit_pkg::OP_FENCE : commit_pkg::OP_FENCE_I;
    end
    s.rd        = 5'(take_bits(5));
    // atomics and csr accesses target the gpr file only
    s.rd_is_fpr = coin() && s.op != commit_pkg::OP_AMO && s.fu != commit_pkg::CSR;
    s.result    = take_bits(64);
    s.ex.valid  = chance((mode == 1 || mode == 5) ? 2 : 3);
    s.ex.cause  = take_bits(64);
    s.ex.tval   = take_bits(64);
    return s;
  endfunction

  task automatic drive_inputs();
    commit_pkg::sb_entry_t e0;
    e0 = new_entry(0);
    // a refused store stays offered
    if (mode == 3 && commit_instr_i[0].valid && commit_instr_i[0].fu == commit_pkg::STORE
        && !commit_ack_o[0]) begin
      e0 = commit_instr_i[0];
    end
    commit_instr_i[0]      = e0;
    commit_instr_i[1]      = new_entry(1);
    commit_drop_i          = {chance(3), chance(3)};
    halt_i                 = chance(4);
    single_step_i          = chance(mode == 2 ? 2 : 3);
    commit_lsu_ready_i     = (mode == 3) ? coin() : !chance(2);
    no_st_pending_i        = coin();
    amo_resp_i.ack         = chance(mode == 6 ? 1 : 3);
    amo_resp_i.result      = take_bits(64);
    csr_rdata_i            = take_bits(64);
    csr_exception_i.valid  = chance(mode == 5 ? 2 : 4);
    csr_exception_i.cause  = take_bits(64);
    csr_exception_i.tval   = take_bits(64);
    fp_status_clr_i        = chance(4);
  endtask

  // --------------------------------------------------------------------------
  // reference
  // --------------------------------------------------------------------------
  function automatic expect_t predict();
    expect_t               e;
    commit_pkg::sb_entry_t a;
    commit_pkg::sb_entry_t b;
    logic                  keep;
    logic                  live;
    logic                  clean;
    logic                  amo;
    logic                  csr;
    logic                  store;
    logic                  fpr;
    logic                  blocked;
    logic                  fenced;
    logic                  fpu0;
    logic                  fpu1;
    a       = commit_instr_i[0];
    b       = commit_instr_i[1];
    e       = '0;
    keep    = !commit_drop_i[0];
    live    = a.valid && !halt_i;
    clean   = live && !a.ex.valid;
    amo     = AMO_PRESENT && a.op == commit_pkg::OP_AMO;
    csr     = a.fu == commit_pkg::CSR;
    store   = a.fu == commit_pkg::STORE && !amo;
    fpr     = FP_PRESENT && a.rd_is_fpr;
    blocked = clean && csr && keep && csr_exception_i.valid;
    fenced  = keep && (a.op == commit_pkg::OP_FENCE || a.op == commit_pkg::OP_FENCE_I);
    // a faulting entry leaves only when dropped
    // any other entry has to pass every gate
    e.ack[0] = (live && a.ex.valid && !keep)
               || (clean && !blocked && (!store || commit_lsu_ready_i)
                   && (!fenced || no_st_pending_i) && (!amo || amo_resp_i.ack));
    e.fence   = clean && fenced && a.op == commit_pkg::OP_FENCE && no_st_pending_i;
    e.fence_i = clean && fenced && a.op == commit_pkg::OP_FENCE_I && no_st_pending_i;
    // port 0 write data prefers the amo result over csr read data
    e.w0.waddr  = a.rd;
    e.w0.wdata  = a.result;
    if (clean && csr && keep && !csr_exception_i.valid) begin
      e.w0.wdata = csr_rdata_i;
    end
    if (AMO_PRESENT && amo_resp_i.ack) begin
      e.w0.wdata = amo_resp_i.result;
    end
    e.w0.we_fpr = clean && keep && fpr;
    e.w0.we_gpr = amo ? (clean && amo_resp_i.ack) : (clean && keep && !fpr && !blocked);
    e.csr.op    = commit_pkg::CSR_NOP;
    if (clean && csr) begin
      e.csr.op    = a.op;
      e.csr.wdata = a.result;
    end
    e.csr_commit = clean && csr && keep && !csr_exception_i.valid;
    e.lsu        = clean && store && commit_lsu_ready_i;
    e.amo_valid  = clean && amo;
    e.flush      = clean && amo && amo_resp_i.ack;
    // port 1 pairs only behind a plain port 0 retirement
    e.ack[1] = e.ack[0] && !csr && !amo && !single_step_i && b.valid && !b.ex.valid
               && b.fu inside {commit_pkg::ALU, commit_pkg::LOAD, commit_pkg::CTRL_FLOW,
                               commit_pkg::MULT, commit_pkg::FPU};
    e.w1.waddr  = b.rd;
    e.w1.wdata  = b.result;
    e.w1.we_fpr = e.ack[1] && !commit_drop_i[1] && FP_PRESENT && b.rd_is_fpr;
    e.w1.we_gpr = e.ack[1] && !commit_drop_i[1] && !(FP_PRESENT && b.rd_is_fpr);
    // earlier exception beats the csr file
    if (a.valid && keep && a.ex.valid) begin
      e.ex = a.ex;
    end else if (a.valid && keep && csr_exception_i.valid) begin
      e.ex.valid = 1'b1;
      e.ex.cause = csr_exception_i.cause;
      e.ex.tval  = a.ex.tval;
    end
    // halt masks both
    if (halt_i) begin
      e.ex.valid = 1'b0;
    end
    // retired fpu work on either port
    fpu0 = FP_PRESENT && e.ack[0] && a.fu == commit_pkg::FPU;
    fpu1 = FP_PRESENT && e.ack[1] && b.fu == commit_pkg::FPU;
    // any retired fpu entry or fpr write dirties the fp state
    e.dirty_set = fpu0 || fpu1 || (e.ack[0] && e.w0.we_fpr) || e.w1.we_fpr;
    // flags accrue only from fpu entries that were not squashed
    if (fpu0 && keep) begin
      e.flags_set = e.flags_set | a.ex.cause[4:0];
    end
    if (fpu1 && !commit_drop_i[1]) begin
      e.flags_set = e.flags_set | b.ex.cause[4:0];
    end
    return e;
  endfunction

  task automatic check(string what, logic [159:0] got, logic [159:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %t: %s got %0h expected %0h", $realtime, what, got, exp);
    end
  endtask

  // --------------------------------------------------------------------------
  // compare just before each rising edge
  // --------------------------------------------------------------------------
  initial begin : compare
    expect_t e;
    forever begin
      @(posedge clk_i);
      #(SAMPLE_DELAY);
      if (arst_n_i) begin
        e = predict();
        check("ack", 160'(commit_ack_o), 160'(e.ack));
        check("port 0 write", 160'(wb_o[0]), 160'(e.w0));
        check("port 1 write", 160'(wb_o[1]), 160'(e.w1));
        check("csr request", 160'(csr_req_o), 160'(e.csr));
        check("strobes", 160'({commit_csr_o, commit_lsu_o, amo_valid_commit_o, fence_o,
                               fence_i_o, flush_commit_o}),
              160'({e.csr_commit, e.lsu, e.amo_valid, e.fence, e.fence_i, e.flush}));
        check("exception", 160'(exception_o), 160'(e.ex));
        check("pc", 160'(pc_o), 160'(commit_instr_i[0].pc));
        check("trans id", 160'(commit_tran_id_o), 160'(commit_instr_i[0].trans_id));
        check("fflags", 160'(fflags_o), 160'(flags_q));
        check("fs dirty", 160'(fs_dirty_o), 160'(dirty_q));
        // status registers take this cycle's work at the coming edge
        if (fp_status_clr_i) begin
          flags_q = '0;
          dirty_q = 1'b0;
        end else begin
          flags_q = flags_q | e.flags_set;
          dirty_q = dirty_q | e.dirty_set;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Error: run timed out after %0d ns without finishing the tests", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  task automatic run_test(int num, string name);
    int err0;
    err0 = errors;
    mode = num;
    repeat (TEST_CYCLES) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      drive_inputs();
    end
    @(posedge clk_i);
    $display("test %0d %s %0d cycles, %0d mismatches", num, name, TEST_CYCLES,
             errors - err0);
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin : main
    $timeformat(-9, 0, " ns", 0);
    lfsr               = SEED;
    mode               = 0;
    errors             = 0;
    checks             = 0;
    flags_q            = '0;
    dirty_q            = 1'b0;
    clk_i              = 1'b0;
    arst_n_i           = 1'b0;
    commit_instr_i     = '0;
    commit_drop_i      = '0;
    halt_i             = 1'b0;
    single_step_i      = 1'b0;
    commit_lsu_ready_i = 1'b0;
    no_st_pending_i    = 1'b0;
    amo_resp_i         = '0;
    csr_rdata_i        = '0;
    csr_exception_i    = '0;
    fp_status_clr_i    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #(DRIVE_DELAY);
    arst_n_i = 1'b1;
    run_test(1, "single");
    run_test(2, "dual");
    run_test(3, "store");
    run_test(4, "fence");
    run_test(5, "csr");
    run_test(6, "amo");
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
common/commit_pkg.sv
commit/commit_lead.sv
commit/commit_follow.sv
src/commit_exception.sv
src/fp_status.sv
src/commit_stage.sv
dv/commit_stage_assert.sv
dv/tb_commit_stage.sv

// ==== Makefile ====
# verilator build, run and lint for the commit stage

VERILATOR ?= verilator
TOP       ?= tb_commit_stage
LINT_TOP  ?= commit_stage
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Simulation failed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
